/* tb.f */
+incdir+include
verilog/seq_pkg.sv
verilog/instr_decoder.sv
verilog/branch_cond.sv
verilog/exception_regs.sv
verilog/control_sequencer.sv
verilog/control.sv
testbench/tb_control.sv

/* Bender.yml */
package:
  name: control_sequencer

sources:
  - include_dirs:
      - include
    files:
      - verilog/seq_pkg.sv
      - verilog/instr_decoder.sv
      - verilog/branch_cond.sv
      - verilog/exception_regs.sv
      - verilog/control_sequencer.sv
      - verilog/control.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_control.sv

/* testbench/tb_control.sv */
`timescale 1ns/1ps
`include "seq_consts.svh"

module tb_control;

  localparam int K_NONE = 0, K_REG = 1, K_ALU = 2, K_CMP = 3, K_BR = 4;
  localparam int K_LD = 5, K_ST = 6, K_EXC = 7, K_RTI = 8, K_IRQ = 9;

  logic clock, reset_n, bus_wait;
  logic [31:0] ir;
  logic [3:0] ccr;
  logic [2:0] interrupt;
  logic ir_write, ccr_write, reg_write, addrsel, bus_read, bus_write, int_en;
  logic [2:0] alu_func, alu2sel, mdrsel, pcsel;
  logic [3:0] regsel, reg_read_addr1, reg_read_addr2, reg_write_addr, exception;
  logic [1:0] marsel;

  // stimulus table
  logic [31:0] t_ir[0:127];
  logic [3:0] t_ccr[0:127], t_addr[0:127], t_regsel[0:127], t_exc[0:127];
  logic [2:0] t_int[0:127];
  int t_kind[0:127];
  logic t_taken[0:127], t_ien[0:127];
  int n_entries, errors, cycles, limit;

  logic [15:0] lfsr;
  logic prev_rd, prev_wr, prev_wait, active;
  int wait_left;
  logic [2:0] last_pc;

  control dut (
    .clock(clock), .reset_n(reset_n), .ir(ir), .ccr(ccr), .bus_wait(bus_wait),
    .interrupt(interrupt), .ir_write(ir_write), .ccr_write(ccr_write),
    .alu_func(alu_func), .alu2sel(alu2sel), .regsel(regsel),
    .reg_read_addr1(reg_read_addr1), .reg_read_addr2(reg_read_addr2),
    .reg_write_addr(reg_write_addr), .reg_write(reg_write), .mdrsel(mdrsel),
    .marsel(marsel), .pcsel(pcsel), .addrsel(addrsel), .bus_read(bus_read),
    .bus_write(bus_write), .int_en(int_en), .exception(exception)
  );

  always #20 clock = ~clock;

  always @(posedge clock) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout after %0d cycles, the sequencer stopped making progress", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic logic next_bit();  // galois lfsr stepped once per bit
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b)
      lfsr = lfsr ^ 16'hb400;
    return b;
  endfunction

  function automatic int draw_wait();
    int v;
    v = next_bit();
    v = v | (next_bit() << 1);
    return (v == 3) ? 2 : v;
  endfunction

  // branch rules with ccr as {carry, negative, overflow, zero}
  function automatic logic branch_rule(input logic [3:0] code, input logic [3:0] f);
    logic c, n, v, z;
    {c, n, v, z} = f;
    case (code)
      4'd0: return 1'b1;
      4'd1: return z;
      4'd2: return !z;
      4'd3: return !z && !c;
      4'd4: return !z && (n == v);
      4'd5: return n == v;
      4'd6: return z || (n != v);
      4'd7: return n != v;
      4'd8: return !c;
      4'd9: return c;
      4'd10: return c || z;
      default: return 1'b0;
    endcase
  endfunction

  // select codes each kind should use, one bit per code
  function automatic logic [7:0] alu2_codes(input int kind, input logic [3:0] sel);
    logic [7:0] m;
    m = 8'h01;  // second read port in every fetch
    if (kind == K_REG && sel == `REGSEL_ALU)
      m[`ALU2_ONE] = 1'b1;  // inc and dec
    if (kind == K_LD || kind == K_ST)
      m[`ALU2_SVAL] = 1'b1;
    if (kind == K_EXC || kind == K_IRQ || kind == K_RTI)
      m[`ALU2_FOUR] = 1'b1;  // stack pointer step
    return m;
  endfunction

  function automatic logic [7:0] mdr_codes(input int kind);
    logic [7:0] m;
    m = 8'h01;
    if (kind == K_LD)
      m[`MDR_BUS] = 1'b1;
    if (kind == K_ST)
      m[`MDR_REG] = 1'b1;
    if (kind == K_EXC || kind == K_IRQ)
      m[`MDR_PC] = 1'b1;  // pushed return address
    return m;
  endfunction

  function automatic logic [3:0] mar_codes(input int kind);
    logic [3:0] m;
    m = 4'h1;
    if (kind == K_LD || kind == K_ST || kind == K_EXC || kind == K_IRQ)
      m[`MAR_ALU] = 1'b1;
    if (kind == K_EXC || kind == K_IRQ || kind == K_RTI)
      m[`MAR_BUS] = 1'b1;  // vector or return address
    if (kind == K_RTI)
      m[`MAR_SP] = 1'b1;
    return m;
  endfunction

  function automatic logic [31:0] reg_op(input logic [6:0] op, input logic [3:0] a,
                                         input logic [3:0] b, input logic [3:0] c);
    return {2'b00, op, 3'b000, a, b, c, 8'h00};
  endfunction

  function automatic logic [31:0] imm_op(input logic [3:0] op, input logic [3:0] a);
    return {2'b10, op, 6'b0, a, 16'h1234};
  endfunction

  task automatic add_entry(input logic [31:0] w, input logic [3:0] f, input logic [2:0] irq,
                           input int kind, input logic [3:0] addr, input logic [3:0] sel,
                           input logic tk, input logic [3:0] exc, input logic ien);
    t_ir[n_entries] = w;
    t_ccr[n_entries] = f;
    t_int[n_entries] = irq;
    t_kind[n_entries] = kind;
    t_addr[n_entries] = addr;
    t_regsel[n_entries] = sel;
    t_taken[n_entries] = tk;
    t_exc[n_entries] = exc;
    t_ien[n_entries] = ien;
    n_entries++;
  endtask

  task automatic check_eq(input string name, input int exp, input int act);
    assert (exp == act) else begin
      $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
      errors++;
    end
  endtask

  // bus model and bus checks for one falling edge
  task automatic bus_model();
    assert (!(interrupt == 0 && prev_wait && prev_rd && !bus_read)) else begin
      $display("%0t bus_read dropped while bus_wait was high", $time);
      errors++;
    end
    assert (!(prev_wait && prev_wr && !bus_write)) else begin
      $display("%0t bus_write dropped while bus_wait was high", $time);
      errors++;
    end
    assert (!ir_write || (prev_rd && !prev_wait)) else begin
      $display("%0t ir_write came before the bus read completed", $time);
      errors++;
    end
    if ((bus_read && !prev_rd) || (bus_write && !prev_wr)) begin
      wait_left = draw_wait();
      active = 1'b1;
    end
    if (active) begin
      bus_wait = (wait_left > 0);
      if (wait_left > 0)
        wait_left--;
      else
        active = 1'b0;
    end else begin
      bus_wait = 1'b0;
    end
    prev_rd = bus_read;
    prev_wr = bus_write;
    prev_wait = bus_wait;
  endtask

  task automatic run_entry(input int i);
    int nirw, nwr, nsp, nrel, nccr, kind;
    logic seen_inc, after_irw, mrd, mwr, done;
    logic [3:0] waddr, wsel, wrd1, wrd2;
    logic [2:0] wfunc;
    logic [7:0] a2_seen, mdr_seen;
    logic [3:0] mar_seen;
    nirw = 0;
    nwr = 0;
    nsp = 0;
    nrel = 0;
    nccr = 0;
    seen_inc = 0;
    after_irw = 0;
    mrd = 0;
    mwr = 0;
    done = 0;
    waddr = 0;
    wsel = 0;
    wrd1 = 0;
    wrd2 = 0;
    wfunc = 0;
    a2_seen = '0;
    mdr_seen = '0;
    mar_seen = '0;
    kind = t_kind[i];
    ccr = t_ccr[i];
    interrupt = t_int[i];
    while (!done) begin
      @(negedge clock);
      if (after_irw)
        check_eq("pcsel after ir_write", `PC_INC, pcsel);
      after_irw = ir_write;
      if (ir_write) begin
        nirw++;
        ir = t_ir[i];  // datapath loads ir on this fetch
      end
      if (pcsel == `PC_INC)
        seen_inc = 1'b1;
      if (pcsel == `PC_REL)
        nrel++;
      if (ccr_write)
        nccr++;
      if (bus_read && addrsel)
        mrd = 1'b1;
      if (bus_write && addrsel)
        mwr = 1'b1;
      if (reg_write) begin
        if (reg_write_addr == `REG_SP) begin
          nsp++;
        end else begin
          nwr++;
          waddr = reg_write_addr;
          wsel = regsel;
          wfunc = alu_func;
          wrd1 = reg_read_addr1;
          wrd2 = reg_read_addr2;
        end
      end
      a2_seen[alu2sel] = 1'b1;
      mdr_seen[mdrsel] = 1'b1;
      mar_seen[marsel] = 1'b1;
      bus_model();
      if (interrupt != 0 && exception == {1'b0, interrupt})
        interrupt = 3'd0;  // request served
      if (seen_inc && last_pc != `PC_VECTOR && bus_read && !addrsel && pcsel == `PC_HOLD)
        done = 1'b1;
      if (pcsel != `PC_HOLD)
        last_pc = pcsel;
    end
    check_eq("ir_write count", 1, nirw);
    check_eq("reg_write count", (kind == K_REG || kind == K_ALU || kind == K_LD), nwr);
    check_eq("sp write count", (kind == K_EXC || kind == K_IRQ || kind == K_RTI), nsp);
    check_eq("pcsel rel", (kind == K_BR) ? t_taken[i] : 0, nrel);
    check_eq("ccr_write count", kind == K_CMP, nccr);
    check_eq("bus_read mem", (kind == K_LD || kind == K_RTI), mrd);
    check_eq("bus_write mem", (kind == K_ST || kind == K_EXC || kind == K_IRQ), mwr);
    check_eq("alu2sel codes", alu2_codes(kind, t_regsel[i]), a2_seen);
    check_eq("mdrsel codes", mdr_codes(kind), mdr_seen);
    check_eq("marsel codes", mar_codes(kind), mar_seen);
    if (nwr == 1) begin
      check_eq("reg_write_addr", t_addr[i], waddr);
      check_eq("regsel", t_regsel[i], wsel);
    end
    if (kind == K_ALU) begin
      check_eq("alu_func", t_ir[i][25:23], wfunc);
      check_eq("reg_read_addr1", t_ir[i][15:12], wrd1);
      check_eq("reg_read_addr2", t_ir[i][11:8], wrd2);
    end
    check_eq("exception", t_exc[i], exception);
    check_eq("int_en", t_ien[i], int_en);
  endtask

  task automatic build_table();
    logic [3:0] flags[0:4];
    flags[0] = 4'b0000;
    flags[1] = 4'b0001;
    flags[2] = 4'b1000;
    flags[3] = 4'b0100;
    flags[4] = 4'b0110;
    add_entry(reg_op(7'h00, 0, 0, 0), 0, 0, K_NONE, 0, 0, 0, 0, 0);
    add_entry(reg_op(7'h03, 1, 0, 0), 0, 0, K_REG, 1, `REGSEL_ALU, 0, 0, 0);
    add_entry(reg_op(7'h04, 2, 0, 0), 0, 0, K_REG, 2, `REGSEL_ALU, 0, 0, 0);
    add_entry(reg_op(7'h0a, 3, 4, 0), 0, 0, K_REG, 3, `REGSEL_RB, 0, 0, 0);
    add_entry(reg_op(7'h0b, 5, 1, 0), 0, 0, K_REG, 5, `REGSEL_COM, 0, 0, 0);
    add_entry(reg_op(7'h0c, 6, 1, 0), 0, 0, K_REG, 6, `REGSEL_NEG, 0, 0, 0);
    add_entry(reg_op(7'h22, 7, 8, 9), 0, 0, K_ALU, 7, `REGSEL_ALU, 0, 0, 0);
    add_entry(reg_op(7'h2d, 10, 11, 12), 0, 0, K_ALU, 10, `REGSEL_ALU, 0, 0, 0);
    add_entry(reg_op(7'h09, 1, 2, 0), 0, 0, K_CMP, 0, 0, 0, 0, 0);
    add_entry(imm_op(4'hc, 4), 0, 0, K_REG, 4, `REGSEL_UIMM, 0, 0, 0);
    for (int c = 0; c < 12; c++)
      for (int f = 0; f < 5; f++)
        add_entry(imm_op(c[3:0], 0), flags[f], 0, K_BR, 0, 0,
                  branch_rule(c[3:0], flags[f]), 0, 0);
    add_entry({2'b01, 4'h1, 6'b0, 4'd5, 4'd6, 12'h0}, 0, 0, K_LD, 5, `REGSEL_MDR, 0, 0, 0);
    add_entry({2'b01, 4'h0, 6'b0, 4'd5, 4'd6, 12'h0}, 0, 0, K_ST, 0, 0, 0, 0, 0);
    add_entry(reg_op(7'h7f, 0, 0, 0), 0, 0, K_EXC, 0, 0, 0, `EXC_BAD_OP, 0);
    add_entry({2'b11, 6'h32, 21'b0, 3'd5}, 0, 0, K_EXC, 0, 0, 0, 4'd13, 0);
    add_entry(reg_op(7'h15, 0, 0, 0), 0, 0, K_NONE, 0, 0, 0, 4'd13, 1);
    add_entry(reg_op(7'h00, 0, 0, 0), 0, 3'd6, K_IRQ, 0, 0, 0, 4'd6, 0);
    add_entry(reg_op(7'h02, 0, 0, 0), 0, 0, K_RTI, 0, 0, 0, 0, 1);
    add_entry(reg_op(7'h14, 0, 0, 0), 0, 0, K_NONE, 0, 0, 0, 0, 0);
    add_entry(reg_op(7'h00, 0, 0, 0), 0, 3'd3, K_NONE, 0, 0, 0, 0, 0);  // masked request
  endtask

  initial begin
    int stage;
    clock = 0;
    reset_n = 0;
    bus_wait = 0;
    ir = 0;
    ccr = 0;
    interrupt = 0;
    lfsr = 16'd42439;
    prev_rd = 0;
    prev_wr = 0;
    prev_wait = 0;
    active = 0;
    wait_left = 0;
    last_pc = `PC_HOLD;
    errors = 0;
    cycles = 0;
    n_entries = 0;
    limit = 1000000;
    build_table();
    limit = 24 * n_entries + 40;
    repeat (5) begin
      @(negedge clock);
      check_eq("reset strobes", 0, {ir_write, ccr_write, reg_write, bus_read, bus_write});
      check_eq("int_en", 0, int_en);
      check_eq("exception", 0, exception);
    end
    reset_n = 1;
    stage = 0;  // vector fetch goes PC_VECTOR then bus_read then PC_MAR
    forever begin
      @(negedge clock);
      if (stage == 0 && pcsel == `PC_VECTOR)
        stage = 1;
      else if (stage == 1 && bus_read)
        stage = 2;
      else if (stage == 2 && pcsel == `PC_MAR)
        stage = 3;
      bus_model();
      if (stage == 3 && bus_read && !addrsel && pcsel == `PC_HOLD)
        break;
    end
    for (int i = 0; i < n_entries; i++)
      run_entry(i);
    $display("checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* verilog/control.sv */
`timescale 1ns/1ps
`include "seq_consts.svh"

module control (
  input  logic                   clock,
  input  logic                   reset_n,
  input  logic [`WORD_W-1:0]     ir,
  input  logic [`CCR_W-1:0]      ccr,
  input  logic                   bus_wait,
  input  logic [2:0]             interrupt,
  output logic                   ir_write,
  output logic                   ccr_write,
  output logic [`ALU_FUNC_W-1:0] alu_func,
  output logic [`ALU2SEL_W-1:0]  alu2sel,
  output logic [`REGSEL_W-1:0]   regsel,
  output logic [`REG_ADDR_W-1:0] reg_read_addr1,
  output logic [`REG_ADDR_W-1:0] reg_read_addr2,
  output logic [`REG_ADDR_W-1:0] reg_write_addr,
  output logic                   reg_write,
  output logic [`MDRSEL_W-1:0]   mdrsel,
  output logic [`MARSEL_W-1:0]   marsel,
  output logic [`PCSEL_W-1:0]    pcsel,
  output logic                   addrsel,
  output logic                   bus_read,
  output logic                   bus_write,
  output logic                   int_en,
  output logic [`CAUSE_W-1:0]    exception
);

  seq_pkg::instr_class_t instr_class;
  logic [`REG_ADDR_W-1:0] ra, rb, rc;
  logic [`ALU_FUNC_W-1:0] alu_op;
  logic [3:0]             cond_code;
  logic [2:0]             trap_num;
  logic                   taken;
  logic                   irq_pending, irq_accept;
  logic                   cause_load;
  logic [`CAUSE_W-1:0]    cause_value;
  logic                   int_set, int_clear, rti_restore;

  instr_decoder u_decoder (
    .ir(ir), .instr_class(instr_class), .ra(ra), .rb(rb), .rc(rc),
    .alu_op(alu_op), .cond_code(cond_code), .trap_num(trap_num)
  );

  branch_cond u_branch_cond (.cond_code(cond_code), .ccr(ccr), .taken(taken));

  exception_regs u_exception_regs (
    .clock(clock), .reset_n(reset_n), .interrupt(interrupt),
    .irq_accept(irq_accept), .cause_load(cause_load), .cause_value(cause_value),
    .int_set(int_set), .int_clear(int_clear), .rti_restore(rti_restore),
    .irq_pending(irq_pending), .int_en(int_en), .exception(exception)
  );

  control_sequencer u_sequencer (
    .clock(clock), .reset_n(reset_n), .instr_class(instr_class),
    .ra(ra), .rb(rb), .rc(rc), .alu_op(alu_op), .trap_num(trap_num),
    .taken(taken), .irq_pending(irq_pending), .exception(exception),
    .bus_wait(bus_wait), .ir_write(ir_write), .ccr_write(ccr_write),
    .alu_func(alu_func), .alu2sel(alu2sel), .regsel(regsel),
    .reg_read_addr1(reg_read_addr1), .reg_read_addr2(reg_read_addr2),
    .reg_write_addr(reg_write_addr), .reg_write(reg_write),
    .mdrsel(mdrsel), .marsel(marsel), .pcsel(pcsel), .addrsel(addrsel),
    .bus_read(bus_read), .bus_write(bus_write),
    .irq_accept(irq_accept), .cause_load(cause_load), .cause_value(cause_value),
    .int_set(int_set), .int_clear(int_clear), .rti_restore(rti_restore)
  );

endmodule

/* verilog/control_sequencer.sv */
`timescale 1ns/1ps
`include "seq_consts.svh"

module control_sequencer (
  input  logic                   clock,
  input  logic                   reset_n,
  input  seq_pkg::instr_class_t  instr_class,
  input  logic [`REG_ADDR_W-1:0] ra,
  input  logic [`REG_ADDR_W-1:0] rb,
  input  logic [`REG_ADDR_W-1:0] rc,
  input  logic [`ALU_FUNC_W-1:0] alu_op,
  input  logic [2:0]             trap_num,
  input  logic                   taken,
  input  logic                   irq_pending,
  input  logic [`CAUSE_W-1:0]    exception,
  input  logic                   bus_wait,
  output logic                   ir_write,
  output logic                   ccr_write,
  output logic [`ALU_FUNC_W-1:0] alu_func,
  output logic [`ALU2SEL_W-1:0]  alu2sel,
  output logic [`REGSEL_W-1:0]   regsel,
  output logic [`REG_ADDR_W-1:0] reg_read_addr1,
  output logic [`REG_ADDR_W-1:0] reg_read_addr2,
  output logic [`REG_ADDR_W-1:0] reg_write_addr,
  output logic                   reg_write,
  output logic [`MDRSEL_W-1:0]   mdrsel,
  output logic [`MARSEL_W-1:0]   marsel,
  output logic [`PCSEL_W-1:0]    pcsel,
  output logic                   addrsel,
  output logic                   bus_read,
  output logic                   bus_write,
  output logic                   irq_accept,
  output logic                   cause_load,
  output logic [`CAUSE_W-1:0]    cause_value,
  output logic                   int_set,
  output logic                   int_clear,
  output logic                   rti_restore
);

  seq_pkg::state_t state, state_next;
  logic [`STEP_W-1:0] step, step_next;
  logic is_load;

  assign is_load = (instr_class == seq_pkg::class_ld_l);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state <= seq_pkg::state_reset;
      step  <= '0;
    end else begin
      state <= state_next;
      step  <= step_next;
    end
  end

  always_comb begin
    state_next     = state;
    step_next      = step;
    ir_write       = 1'b0;
    ccr_write      = 1'b0;
    alu_func       = `ALU_ADD;
    alu2sel        = `ALU2_REG;
    regsel         = `REGSEL_ALU;
    reg_read_addr1 = ra;
    reg_read_addr2 = rb;
    reg_write_addr = ra;
    reg_write      = 1'b0;
    mdrsel         = '0;
    marsel         = '0;
    pcsel          = `PC_HOLD;
    addrsel        = 1'b0;  // PC drives the address bus
    bus_read       = 1'b0;
    bus_write      = 1'b0;
    irq_accept     = 1'b0;
    cause_load     = 1'b0;
    cause_value    = `EXC_BAD_OP;
    int_set        = 1'b0;
    int_clear      = 1'b0;
    rti_restore    = 1'b0;

    case (state)
      seq_pkg::state_reset: begin
        cause_load  = 1'b1;
        cause_value = `EXC_RESET;
        state_next  = seq_pkg::state_exception;
      end
      seq_pkg::state_exception: begin
        case (step)
          3'd0: begin
            if (exception == `EXC_RESET) begin
              step_next = 3'd3;  // nothing to push after reset
            end else begin
              alu2sel        = `ALU2_FOUR;  // SP - 4
              alu_func       = `ALU_SUB;
              reg_read_addr1 = `REG_SP;
              mdrsel         = `MDR_PC;
              step_next      = 3'd1;
            end
          end
          3'd1: begin
            marsel         = `MAR_ALU;
            reg_write_addr = `REG_SP;
            reg_write      = 1'b1;
            addrsel        = 1'b1;
            bus_write      = 1'b1;
            step_next      = 3'd2;
          end
          3'd2: begin
            addrsel   = 1'b1;
            bus_write = 1'b1;
            if (!bus_wait)
              step_next = 3'd3;
          end
          3'd3: begin
            pcsel     = `PC_VECTOR;  // vector address from cause
            step_next = 3'd4;
          end
          3'd4: begin
            bus_read = 1'b1;
            if (!bus_wait)
              step_next = 3'd5;
          end
          3'd5: begin
            bus_read  = 1'b1;
            marsel    = `MAR_BUS;  // handler address
            step_next = 3'd6;
          end
          default: begin
            pcsel      = `PC_MAR;
            state_next = seq_pkg::state_fetch_ir;
          end
        endcase
      end
      seq_pkg::state_fetch_ir: begin
        case (step)
          3'd0: begin
            bus_read = 1'b1;
            if (irq_pending) begin
              irq_accept = 1'b1;
              state_next = seq_pkg::state_exception;
            end else if (!bus_wait) begin
              step_next = 3'd1;
            end
          end
          3'd1: begin
            bus_read  = 1'b1;
            ir_write  = 1'b1;
            step_next = 3'd2;
          end
          default: begin
            pcsel      = `PC_INC;
            state_next = seq_pkg::state_eval_ir;
          end
        endcase
      end
      default: begin
        state_next = seq_pkg::state_fetch_ir;  // single-cycle classes
        case (instr_class)
          seq_pkg::class_nop: ;
          seq_pkg::class_cmp: begin
            alu_func  = `ALU_SUB;
            ccr_write = 1'b1;
          end
          seq_pkg::class_mov, seq_pkg::class_com, seq_pkg::class_neg: begin
            reg_write = 1'b1;
            if (instr_class == seq_pkg::class_mov)
              regsel = `REGSEL_RB;
            else if (instr_class == seq_pkg::class_com)
              regsel = `REGSEL_COM;
            else
              regsel = `REGSEL_NEG;
          end
          seq_pkg::class_cli: int_clear = 1'b1;
          seq_pkg::class_sti: int_set = 1'b1;
          seq_pkg::class_branch: begin
            if (taken)
              pcsel = `PC_REL;
          end
          seq_pkg::class_ldiu: begin
            regsel    = `REGSEL_UIMM;
            reg_write = 1'b1;
          end
          seq_pkg::class_inc, seq_pkg::class_dec, seq_pkg::class_alu_rr: begin
            if (instr_class == seq_pkg::class_alu_rr) begin
              alu_func       = alu_op;
              reg_read_addr1 = rb;
              reg_read_addr2 = rc;
            end else begin
              alu2sel  = `ALU2_ONE;
              alu_func = (instr_class == seq_pkg::class_dec) ? `ALU_SUB : `ALU_ADD;
            end
            if (step == 3'd0) begin
              state_next = state;  // let the ALU result settle
              step_next  = 3'd1;
            end else begin
              reg_write = 1'b1;
            end
          end
          seq_pkg::class_ld_l, seq_pkg::class_st_l: begin
            addrsel = 1'b1;  // MAR
            if (step != 3'd3)
              state_next = state;
            case (step)
              3'd0: begin
                reg_read_addr1 = rb;
                alu2sel        = `ALU2_SVAL;  // rb + offset
                step_next      = 3'd1;
              end
              3'd1: begin
                marsel    = `MAR_ALU;
                mdrsel    = is_load ? mdrsel : `MDR_REG;
                step_next = 3'd2;
              end
              3'd2: begin
                bus_read  = is_load;
                bus_write = !is_load;
                mdrsel    = is_load ? `MDR_BUS : mdrsel;
                if (!bus_wait)
                  step_next = 3'd3;
              end
              default: begin
                regsel    = `REGSEL_MDR;
                reg_write = is_load;
              end
            endcase
          end
          seq_pkg::class_rti: begin
            if (step != 3'd3)
              state_next = state;
            case (step)
              3'd0: begin
                rti_restore    = 1'b1;
                reg_read_addr1 = `REG_SP;
                marsel         = `MAR_SP;
                step_next      = 3'd1;
              end
              3'd1: begin
                addrsel  = 1'b1;
                bus_read = 1'b1;
                if (!bus_wait)
                  step_next = 3'd2;
              end
              3'd2: begin
                addrsel        = 1'b1;
                bus_read       = 1'b1;
                marsel         = `MAR_BUS;  // return address
                alu2sel        = `ALU2_FOUR;
                reg_read_addr1 = `REG_SP;
                step_next      = 3'd3;
              end
              default: begin
                pcsel          = `PC_MAR;
                reg_write_addr = `REG_SP;  // SP + 4
                reg_write      = 1'b1;
              end
            endcase
          end
          seq_pkg::class_trap: begin
            cause_load  = 1'b1;
            cause_value = {1'b1, trap_num};  // software causes 8..15
            state_next  = seq_pkg::state_exception;
          end
          default: begin
            cause_load = 1'b1;  // bad opcode
            state_next = seq_pkg::state_exception;
          end
        endcase
      end
    endcase

    // every state change starts again at step 0
    if (state_next != state)
      step_next = '0;
  end

endmodule

/* verilog/exception_regs.sv */
`timescale 1ns/1ps
`include "seq_consts.svh"

module exception_regs (
  input  logic                clock,
  input  logic                reset_n,
  input  logic [2:0]          interrupt,
  input  logic                irq_accept,
  input  logic                cause_load,
  input  logic [`CAUSE_W-1:0] cause_value,
  input  logic                int_set,
  input  logic                int_clear,
  input  logic                rti_restore,
  output logic                irq_pending,
  output logic                int_en,
  output logic [`CAUSE_W-1:0] exception
);

  assign irq_pending = (|interrupt) & int_en;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      int_en    <= 1'b0;
      exception <= `EXC_RESET;
    end else if (irq_accept) begin
      exception <= {1'b0, interrupt};  // hardware causes 1..7
      int_en    <= 1'b0;
    end else if (rti_restore) begin
      exception <= `EXC_RESET;
      int_en    <= 1'b1;
    end else begin
      if (cause_load)
        exception <= cause_value;
      if (int_set)
        int_en <= 1'b1;
      else if (int_clear)
        int_en <= 1'b0;
    end
  end

endmodule

/* verilog/branch_cond.sv */
`timescale 1ns/1ps
`include "seq_consts.svh"

module branch_cond (
  input  logic [3:0]        cond_code,
  input  logic [`CCR_W-1:0] ccr,
  output logic              taken
);

  logic carry, negative, overflow, zero;
  logic lt;  // signed less-than

  assign {carry, negative, overflow, zero} = ccr;
  assign lt = negative ^ overflow;

  always_comb begin
    case (cond_code)
      4'h0:    taken = 1'b1;           // bra
      4'h1:    taken = zero;           // beq
      4'h2:    taken = ~zero;          // bne
      4'h3:    taken = ~(zero | carry);  // bgtu
      4'h4:    taken = ~(zero | lt);   // bgt
      4'h5:    taken = ~lt;            // bge
      4'h6:    taken = zero | lt;      // ble
      4'h7:    taken = lt;             // blt
      4'h8:    taken = ~carry;         // bgeu
      4'h9:    taken = carry;          // bltu
      4'ha:    taken = carry | zero;   // bleu
      default: taken = 1'b0;           // brn, ldiu and unused codes
    endcase
  end

endmodule

/* verilog/instr_decoder.sv */
`timescale 1ns/1ps
`include "seq_consts.svh"

module instr_decoder (
  input  logic [`WORD_W-1:0]      ir,
  output seq_pkg::instr_class_t   instr_class,
  output logic [`REG_ADDR_W-1:0]  ra,
  output logic [`REG_ADDR_W-1:0]  rb,
  output logic [`REG_ADDR_W-1:0]  rc,
  output logic [`ALU_FUNC_W-1:0]  alu_op,
  output logic [3:0]              cond_code,
  output logic [2:0]              trap_num
);

  seq_pkg::mode_t mode;
  logic [6:0] op_reg;    // register mode opcode
  logic [3:0] op_short;  // register-indirect and immediate opcode
  logic [5:0] op_dir;    // direct mode opcode

  assign mode     = seq_pkg::mode_t'(ir[31:30]);
  assign op_reg   = ir[29:23];
  assign op_short = ir[29:26];
  assign op_dir   = ir[29:24];

  assign ra        = ir[19:16];
  assign rb        = ir[15:12];
  assign rc        = ir[11:8];
  assign alu_op    = op_reg[2:0];
  assign cond_code = op_short;
  assign trap_num  = ir[2:0];

  always_comb begin
    instr_class = seq_pkg::class_illegal;
    case (mode)
      seq_pkg::mode_reg: begin
        case (op_reg) inside
          7'h00:          instr_class = seq_pkg::class_nop;
          7'h02:          instr_class = seq_pkg::class_rti;
          7'h03:          instr_class = seq_pkg::class_inc;
          7'h04:          instr_class = seq_pkg::class_dec;
          7'h09:          instr_class = seq_pkg::class_cmp;
          7'h0a:          instr_class = seq_pkg::class_mov;
          7'h0b:          instr_class = seq_pkg::class_com;
          7'h0c:          instr_class = seq_pkg::class_neg;
          7'h14:          instr_class = seq_pkg::class_cli;
          7'h15:          instr_class = seq_pkg::class_sti;
          [7'h20:7'h2f]:  instr_class = seq_pkg::class_alu_rr;
          default:        instr_class = seq_pkg::class_illegal;
        endcase
      end
      seq_pkg::mode_regind: begin
        if (op_short == 4'h0)
          instr_class = seq_pkg::class_st_l;
        else if (op_short == 4'h1)
          instr_class = seq_pkg::class_ld_l;
      end
      seq_pkg::mode_imm: begin
        if (op_short <= 4'hb)
          instr_class = seq_pkg::class_branch;  // bra .. brn
        else if (op_short == 4'hc)
          instr_class = seq_pkg::class_ldiu;
      end
      default: begin
        if (op_dir == 6'h32)
          instr_class = seq_pkg::class_trap;  // only direct op left
      end
    endcase
  end

endmodule

/* verilog/seq_pkg.sv */
package seq_pkg;

  typedef enum logic [1:0] {
    state_reset,
    state_exception,
    state_fetch_ir,
    state_eval_ir
  } state_t;

  // addressing mode, ir[31:30]
  typedef enum logic [1:0] {
    mode_reg    = 2'd0,
    mode_regind = 2'd1,
    mode_imm    = 2'd2,
    mode_dir    = 2'd3
  } mode_t;

  typedef enum logic [4:0] {
    class_nop,
    class_rti,
    class_inc,
    class_dec,
    class_cmp,
    class_mov,
    class_com,
    class_neg,
    class_cli,
    class_sti,
    class_alu_rr,  // ra <= rb op rc
    class_branch,
    class_ldiu,
    class_ld_l,
    class_st_l,
    class_trap,
    class_illegal
  } instr_class_t;

endpackage

/* include/seq_consts.svh */
`ifndef SEQ_CONSTS_SVH
`define SEQ_CONSTS_SVH

// datapath widths
`define WORD_W      32
`define REG_ADDR_W  4
`define STEP_W      3
`define CCR_W       4
`define CAUSE_W     4

// select-code widths
`define ALU_FUNC_W  3
`define ALU2SEL_W   3
`define REGSEL_W    4
`define MDRSEL_W    3
`define MARSEL_W    2
`define PCSEL_W     3

`define ALU_ADD     3'd2
`define ALU_SUB     3'd3

`define ALU2_REG    3'd0  // second read port
`define ALU2_SVAL   3'd1  // signed immediate
`define ALU2_ONE    3'd2
`define ALU2_FOUR   3'd4

`define REGSEL_ALU  4'd0
`define REGSEL_MDR  4'd1
`define REGSEL_NEG  4'd2
`define REGSEL_COM  4'd3
`define REGSEL_RB   4'd4
`define REGSEL_UIMM 4'd6  // zero-extended 16-bit immediate

`define MDR_BUS     3'd1
`define MDR_REG     3'd3
`define MDR_PC      3'd6

`define MAR_BUS     2'd1
`define MAR_ALU     2'd2
`define MAR_SP      2'd3

`define PC_HOLD     3'd0
`define PC_INC      3'd1
`define PC_MAR      3'd2
`define PC_REL      3'd3
`define PC_VECTOR   3'd5

`define REG_SP      4'd15

`define EXC_RESET   4'd0
`define EXC_BAD_OP  4'd3

`endif
